//--- source/rom_cfg_pkg.sv
//******************************
// ROM is word addressed, 1M words of 32 bits, and client regions must stay disjoint
// Client widths count in each client's own data unit
//******************************
`default_nettype none

package rom_cfg_pkg;

    // External word address width shared by the memory port
    localparam int mem_aw = 20;

    // Client address widths, char in bytes, obj in halfwords, main in words
    localparam int char_aw = 15;
    localparam int obj_aw  = 16;
    localparam int main_aw = 14;

    // Region offsets in words
    // The char region spans 0x2000 words, obj 0x8000 and main 0x4000
    localparam logic [mem_aw-1:0] char_base = 20'h00000;
    localparam logic [mem_aw-1:0] obj_base  = 20'h04000;
    localparam logic [mem_aw-1:0] main_base = 20'h0C000;

    // Slot count and the width of a slot index
    localparam int n_slots = 3;
    localparam int slot_w  = $clog2(n_slots);

    // Fixed slot positions, also the round-robin order
    localparam logic [slot_w-1:0] slot_char = 0;
    localparam logic [slot_w-1:0] slot_obj  = 1;
    localparam logic [slot_w-1:0] slot_main = 2;

endpackage

`default_nettype wire

//--- source/rom_data_pkg.sv
//******************************
// Lane 0 of either view holds the least significant bits of the ROM word
//******************************
`default_nettype none

package rom_data_pkg;

    // Width of one ROM word as returned by the memory
    localparam int word_w = 32;

    // One ROM word seen in two ways
    // The char slot picks one of four bytes
    // The obj slot picks one of two halfwords
    // The main slot takes the word as a whole vector
    typedef union packed {
        logic [word_w/8-1:0][7:0]   byte_lane;
        logic [word_w/16-1:0][15:0] half_lane;
    } rom_word_t;

endpackage

`default_nettype wire

//--- source/rom_slot.sv
//******************************
// dw must be 8, 16 or 32 and the client holds addr steady until ok rises
//******************************
`timescale 1ns/1ps
`default_nettype none

module rom_slot #(
    parameter int aw        = 15,
    parameter int dw        = 8,
    parameter bit invert_a0 = 1'b0
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    cen,
    input  wire logic [aw-1:0]           addr,
    input  wire rom_data_pkg::rom_word_t din,
    input  wire logic                    we,
    output logic                         req,
    output logic                         ok,
    output logic [aw-1:0]                addr_req,
    output logic [dw-1:0]                dout
);

    // Cached ROM word and the aligned address it was fetched for
    rom_data_pkg::rom_word_t cached_q;
    logic [aw-1:0]           cached_addr;

    // Set by reset until the first load, so a slot never claims stale data
    logic unloaded;

    // Alignment and lane selection both depend on the client data width
    generate
        if (dw == 8) begin : g_byte
            // Four bytes share one word so two low address bits are dropped
            logic [1:0] lane;

            assign addr_req = {addr[aw-1:2], 2'b00};

            // Some boards store byte pairs swapped, hence the optional inversion of bit 0
            assign lane = {addr[1], addr[0] ^ invert_a0};
            assign dout = cached_q.byte_lane[lane];
        end else if (dw == 16) begin : g_half
            // Two halfwords share one word
            assign addr_req = {addr[aw-1:1], 1'b0};
            assign dout     = cached_q.half_lane[addr[0]];
        end else begin : g_word
            // A full-width client already addresses whole words
            assign addr_req = addr;
            assign dout     = cached_q;
        end
    endgenerate

    // Hit when loaded and the cached word covers the current address
    assign ok = !unloaded && (addr_req == cached_addr);

    // Anything else is a miss and asks the arbiter for a fetch
    assign req = !ok;

    // Load tracking is the only state that reset touches
    always_ff @(posedge clk) begin
        if (rst) begin
            unloaded <= 1'b1;
        end else if (cen && we) begin
            unloaded <= 1'b0;
        end
    end

    // The address is sampled at load time together with the word
    // A client that moves early would tag the word with the wrong address
    always_ff @(posedge clk) begin
        if (cen && we) begin
            cached_q    <= din;
            cached_addr <= addr_req;
        end
    end

endmodule

`default_nettype wire

//--- source/rom_arbiter.sv
//******************************
// One fetch in flight, and mem_rdy is taken as a single-cycle pulse
// Slot addresses are sampled once when a slot wins arbitration
//******************************
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               cen,
    input  wire logic                               char_req,
    input  wire logic                               obj_req,
    input  wire logic                               main_req,
    input  wire logic [rom_cfg_pkg::char_aw-1:0]    char_addr_req,
    input  wire logic [rom_cfg_pkg::obj_aw-1:0]     obj_addr_req,
    input  wire logic [rom_cfg_pkg::main_aw-1:0]    main_addr_req,
    input  wire logic [rom_data_pkg::word_w-1:0]    mem_data,
    input  wire logic                               mem_rdy,
    output logic                                    char_we,
    output logic                                    obj_we,
    output logic                                    main_we,
    output rom_data_pkg::rom_word_t                 din,
    output logic                                    mem_rd,
    output logic [rom_cfg_pkg::mem_aw-1:0]          mem_addr
);

    // Requests gathered in slot order
    logic [rom_cfg_pkg::n_slots-1:0] req_vec;

    // Absolute ROM word address of every slot
    logic [rom_cfg_pkg::mem_aw-1:0] slot_addr [rom_cfg_pkg::n_slots];

    // Last served slot, which also names the slot owning the current fetch
    logic [rom_cfg_pkg::slot_w-1:0] last;

    // Round-robin winner for this cycle and whether there is one at all
    logic [rom_cfg_pkg::slot_w-1:0] pick;
    logic                           found;

    // The state machine is kept as two flags
    // Idle when both are low, fetch while mem_rd is high, load while loading is high
    logic loading;
    logic start;

    assign req_vec[rom_cfg_pkg::slot_char] = char_req;
    assign req_vec[rom_cfg_pkg::slot_obj]  = obj_req;
    assign req_vec[rom_cfg_pkg::slot_main] = main_req;

    // Drop the lane bits to get a word index, then place it in the client region
    assign slot_addr[rom_cfg_pkg::slot_char] = rom_cfg_pkg::char_base +
        {{(rom_cfg_pkg::mem_aw - rom_cfg_pkg::char_aw + 2){1'b0}},
         char_addr_req[rom_cfg_pkg::char_aw-1:2]};
    assign slot_addr[rom_cfg_pkg::slot_obj] = rom_cfg_pkg::obj_base +
        {{(rom_cfg_pkg::mem_aw - rom_cfg_pkg::obj_aw + 1){1'b0}},
         obj_addr_req[rom_cfg_pkg::obj_aw-1:1]};
    assign slot_addr[rom_cfg_pkg::slot_main] = rom_cfg_pkg::main_base +
        {{(rom_cfg_pkg::mem_aw - rom_cfg_pkg::main_aw){1'b0}}, main_addr_req};

    // Walk the slots starting just after the last served one
    // The first requester met wins, so no slot can be starved
    always_comb begin
        logic [rom_cfg_pkg::slot_w-1:0] idx;

        idx   = last;
        found = 1'b0;
        pick  = last;
        for (int i = 0; i < rom_cfg_pkg::n_slots; i++) begin
            if (int'(idx) == rom_cfg_pkg::n_slots - 1) begin
                idx = '0;
            end else begin
                idx = idx + 1'b1;
            end
            if (!found && req_vec[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    // A decision is only taken from idle and on an enabled cycle
    assign start = !mem_rd && !loading && cen && found;

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_rd  <= 1'b0;
            loading <= 1'b0;
            // Start as if main was served so char goes first
            last    <= rom_cfg_pkg::slot_main;
        end else begin
            if (start) begin
                mem_rd <= 1'b1;
                last   <= pick;
            end
            // The ready pulse is honoured even with cen low
            if (mem_rd && mem_rdy) begin
                mem_rd  <= 1'b0;
                loading <= 1'b1;
            end
            // The slot takes the word on this same enabled edge
            if (loading && cen) begin
                loading <= 1'b0;
            end
        end
    end

    // Address and returned data
    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr <= slot_addr[pick];
        end
        if (mem_rd && mem_rdy) begin
            din <= mem_data;
        end
    end

    // Write enables stay up through the load phase until a cen cycle
    assign char_we = loading && (last == rom_cfg_pkg::slot_char);
    assign obj_we  = loading && (last == rom_cfg_pkg::slot_obj);
    assign main_we = loading && (last == rom_cfg_pkg::slot_main);

endmodule

`default_nettype wire

//--- source/rom_subsys.sv
//******************************
// Clients hold their address until ok rises, and cen gates loads and arbitration
// mem_rd is a level held until a one-cycle mem_rdy
//******************************
`timescale 1ns/1ps
`default_nettype none

module rom_subsys (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               cen,

    // Character client, byte addressed
    input  wire logic [rom_cfg_pkg::char_aw-1:0]    char_addr,
    output logic [7:0]                              char_data,
    output logic                                    char_ok,

    // Object client, halfword addressed
    input  wire logic [rom_cfg_pkg::obj_aw-1:0]     obj_addr,
    output logic [15:0]                             obj_data,
    output logic                                    obj_ok,

    // Main CPU client, word addressed
    input  wire logic [rom_cfg_pkg::main_aw-1:0]    main_addr,
    output logic [rom_data_pkg::word_w-1:0]         main_data,
    output logic                                    main_ok,

    // External ROM port
    output logic                                    mem_rd,
    output logic [rom_cfg_pkg::mem_aw-1:0]          mem_addr,
    input  wire logic [rom_data_pkg::word_w-1:0]    mem_data,
    input  wire logic                               mem_rdy
);

    // Miss flags from the slots
    logic char_req;
    logic obj_req;
    logic main_req;

    // Aligned client addresses as seen by the arbiter
    logic [rom_cfg_pkg::char_aw-1:0] char_addr_req;
    logic [rom_cfg_pkg::obj_aw-1:0]  obj_addr_req;
    logic [rom_cfg_pkg::main_aw-1:0] main_addr_req;

    // Per-slot load enables and the word shared by all slots
    logic                    char_we;
    logic                    obj_we;
    logic                    main_we;
    rom_data_pkg::rom_word_t din;

    // Byte lanes of the character ROM come in swapped pairs
    rom_slot #(
        .aw        (rom_cfg_pkg::char_aw),
        .dw        (8),
        .invert_a0 (1'b1)
    ) u_char_slot (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .addr     (char_addr),
        .din      (din),
        .we       (char_we),
        .req      (char_req),
        .ok       (char_ok),
        .addr_req (char_addr_req),
        .dout     (char_data)
    );

    rom_slot #(
        .aw        (rom_cfg_pkg::obj_aw),
        .dw        (16),
        .invert_a0 (1'b0)
    ) u_obj_slot (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .addr     (obj_addr),
        .din      (din),
        .we       (obj_we),
        .req      (obj_req),
        .ok       (obj_ok),
        .addr_req (obj_addr_req),
        .dout     (obj_data)
    );

    rom_slot #(
        .aw        (rom_cfg_pkg::main_aw),
        .dw        (rom_data_pkg::word_w),
        .invert_a0 (1'b0)
    ) u_main_slot (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .addr     (main_addr),
        .din      (din),
        .we       (main_we),
        .req      (main_req),
        .ok       (main_ok),
        .addr_req (main_addr_req),
        .dout     (main_data)
    );

    // Shared access to the external ROM
    rom_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .cen           (cen),
        .char_req      (char_req),
        .obj_req       (obj_req),
        .main_req      (main_req),
        .char_addr_req (char_addr_req),
        .obj_addr_req  (obj_addr_req),
        .main_addr_req (main_addr_req),
        .mem_data      (mem_data),
        .mem_rdy       (mem_rdy),
        .char_we       (char_we),
        .obj_we        (obj_we),
        .main_we       (main_we),
        .din           (din),
        .mem_rd        (mem_rd),
        .mem_addr      (mem_addr)
    );

endmodule

`default_nettype wire

//--- sim/rom_model.sv
//******************************
// Answers each mem_rd after 1 to 6 cycles with a one-cycle mem_rdy
// Contents are computed and cannot be written
//******************************
`timescale 1ns/1ps
`default_nettype none

module rom_model (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        mem_rd,
    input  wire logic [19:0] mem_addr,
    output logic [31:0]      mem_data,
    output logic             mem_rdy
);

    // Fixed seed so every run sees the same latency sequence
    integer      seed = 21313;
    logic        busy;
    int unsigned wait_left;

    // Each word is its own address times a fixed odd constant, truncated to 32 bits
    function automatic logic [31:0] word_at(input logic [19:0] w);
        return {12'h000, w} * 32'h9E3779B1;
    endfunction

    // mem_rd is still high on the edge that carries mem_rdy, so that edge must not restart
    always @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            wait_left <= 0;
            mem_rdy   <= 1'b0;
            mem_data  <= '0;
        end else begin
            mem_rdy <= 1'b0;
            if (busy) begin
                if (wait_left <= 1) begin
                    busy     <= 1'b0;
                    mem_rdy  <= 1'b1;
                    mem_data <= word_at(mem_addr);
                end else begin
                    wait_left <= wait_left - 1;
                end
            end else if (mem_rd && !mem_rdy) begin
                busy      <= 1'b1;
                wait_left <= 1 + ($unsigned($random(seed)) % 6);
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_rom_subsys.sv
//******************************
// Each step waits until all three clients hit, so one fetch per changed word is expected
//******************************
`timescale 1ns/1ps
`default_nettype none

module tb_rom_subsys;

    localparam int n_entries  = 10;
    localparam int wait_limit = 200;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [14:0] char_addr;
    logic [7:0]  char_data;
    logic        char_ok;
    logic [15:0] obj_addr;
    logic [15:0] obj_data;
    logic        obj_ok;
    logic [13:0] main_addr;
    logic [31:0] main_data;
    logic        main_ok;
    logic        mem_rd;
    logic [19:0] mem_addr;
    logic [31:0] mem_data;
    logic        mem_rdy;

    // Stimulus table with one client and one address per entry
    // A cleared hold bit moves the other two clients to new words in the same cycle
    int          tbl_client [n_entries] = '{0, 0, 0, 0, 1, 1, 2, 0, 1, 2};
    logic [15:0] tbl_addr   [n_entries] = '{16'h0123, 16'h0120, 16'h0121, 16'h0122, 16'h1234,
                                            16'h1235, 16'h2A5F, 16'h7FFF, 16'h0777, 16'h3FFF};
    bit          tbl_hold   [n_entries] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
                                            1'b1, 1'b1, 1'b1, 1'b0, 1'b1};

    // Word address of every fetch as sampled on the edge after mem_rd rises
    logic [19:0] fetch_addrs [$];
    logic        rd_seen;

    int error_count;
    int failed_count;

    // Port names match on both sides
    rom_subsys uut (.*);
    rom_model u_rom (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // The clock enable runs at half rate
    always @(posedge clk) begin
        cen <= ~cen;
    end

    // Sampling on the rising edge sees the values of the cycle that just ended
    always @(posedge clk) begin
        if (rst) begin
            rd_seen <= 1'b0;
        end else begin
            if (mem_rd && !rd_seen) begin
                fetch_addrs.push_back(mem_addr);
            end
            rd_seen <= mem_rd;
        end
    end

    // ROM contents are the word address times a fixed odd constant
    function automatic logic [31:0] rom_word_at(input logic [19:0] w);
        return {12'h000, w} * 32'h9E3779B1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h got %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count != errors_before) begin
            failed_count++;
            $display("%s: fail", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    // Wait until every client hits, then check the data and the fetches of this step
    task automatic settle(input string name, input bit [2:0] changed, input int start_cnt);
        int          cycles;
        bit          matched;
        bit          dropped;
        bit [2:0]    used;
        logic [19:0] exp_word [3];
        logic [31:0] word;
        logic [15:0] half;

        cycles  = 0;
        dropped = 1'b0;
        used    = 3'b000;
        while (!(char_ok && obj_ok && main_ok) && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!(char_ok && obj_ok && main_ok)) begin
            $display("%s: ok did not rise on all clients within %0d cycles", name, wait_limit);
            error_count++;
        end else begin
            // A stray request would start a fetch on one of the next two enabled cycles
            repeat (4) begin
                @(negedge clk);
                if (!(char_ok && obj_ok && main_ok)) begin
                    dropped = 1'b1;
                end
            end
            if (dropped) begin
                $display("%s: ok fell again while the addresses were held", name);
                error_count++;
            end
        end

        // Word addresses follow from the region bases and each client's data unit
        exp_word[0] = rom_cfg_pkg::char_base + {7'h00, char_addr[14:2]};
        exp_word[1] = rom_cfg_pkg::obj_base + {5'h00, obj_addr[15:1]};
        exp_word[2] = rom_cfg_pkg::main_base + {6'h00, main_addr};

        // Char bytes sit in swapped pairs so lane bit 0 is the inverse of address bit 0
        word = rom_word_at(exp_word[0]);
        check_value("char_data", {24'h0, word[{char_addr[1], ~char_addr[0], 3'b000} +: 8]},
                    {24'h0, char_data});
        word = rom_word_at(exp_word[1]);
        half = obj_addr[0] ? word[31:16] : word[15:0];
        check_value("obj_data", {16'h0, half}, {16'h0, obj_data});
        check_value("main_data", rom_word_at(exp_word[2]), main_data);

        // Each changed client owns exactly one fetch at its own word address
        if (fetch_addrs.size() - start_cnt != $countones(changed)) begin
            $display("%s: expected %0d fetches but saw %0d", name, $countones(changed),
                     fetch_addrs.size() - start_cnt);
            error_count++;
        end
        for (int i = start_cnt; i < fetch_addrs.size(); i++) begin
            matched = 1'b0;
            for (int c = 0; c < 3; c++) begin
                if (!matched && changed[c] && !used[c] && fetch_addrs[i] == exp_word[c]) begin
                    matched = 1'b1;
                    used[c] = 1'b1;
                end
            end
            if (!matched) begin
                $display("%s: fetch at %h matches no waiting client", name, fetch_addrs[i]);
                error_count++;
            end
        end
    endtask

    initial begin
        int          errors_before;
        int          start_cnt;
        string       name;
        bit [2:0]    changed;
        logic [14:0] new_char;
        logic [15:0] new_obj;
        logic [13:0] new_main;

        error_count  = 0;
        failed_count = 0;
        rst          = 1'b1;
        cen          = 1'b0;
        char_addr    = '0;
        obj_addr     = '0;
        main_addr    = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Every slot starts unloaded and the memory port idle
        @(negedge clk);
        check_value("char_ok", 32'h0, {31'h0, char_ok});
        check_value("obj_ok", 32'h0, {31'h0, obj_ok});
        check_value("main_ok", 32'h0, {31'h0, main_ok});
        check_value("mem_rd", 32'h0, {31'h0, mem_rd});
        report_test("reset state", 0);

        // All clients sit at address zero, so each needs one fetch
        errors_before = error_count;
        settle("initial fill", 3'b111, 0);
        report_test("initial fill", errors_before);

        for (int n = 0; n < n_entries; n++) begin
            errors_before = error_count;
            name          = $sformatf("entry %0d client %0d addr %h", n, tbl_client[n],
                                      tbl_addr[n]);
            new_char      = char_addr;
            new_obj       = obj_addr;
            new_main      = main_addr;
            if (!tbl_hold[n]) begin
                new_char = char_addr + 15'h0104;
                new_obj  = obj_addr + 16'h0082;
                new_main = main_addr + 14'h0041;
            end
            if (tbl_client[n] == 0) begin
                new_char = tbl_addr[n][14:0];
            end else if (tbl_client[n] == 1) begin
                new_obj = tbl_addr[n];
            end else begin
                new_main = tbl_addr[n][13:0];
            end
            changed[0] = new_char[14:2] != char_addr[14:2];
            changed[1] = new_obj[15:1] != obj_addr[15:1];
            changed[2] = new_main != main_addr;
            start_cnt  = fetch_addrs.size();

            @(posedge clk);
            char_addr <= new_char;
            obj_addr  <= new_obj;
            main_addr <= new_main;

            // A new word drops ok in the same cycle while a move inside the word keeps it
            @(negedge clk);
            check_value("char_ok", {31'h0, !changed[0]}, {31'h0, char_ok});
            check_value("obj_ok", {31'h0, !changed[1]}, {31'h0, obj_ok});
            check_value("main_ok", {31'h0, !changed[2]}, {31'h0, main_ok});
            settle(name, changed, start_cnt);
            report_test(name, errors_before);
        end

        $display("%0d tests run, %0d failed, %0d errors", n_entries + 2, failed_count,
                 error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rom_subsys.f
source/rom_cfg_pkg.sv
source/rom_data_pkg.sv
source/rom_slot.sv
source/rom_arbiter.sv
source/rom_subsys.sv
sim/rom_model.sv
sim/tb_rom_subsys.sv

//--- Makefile
# Verilator flow for the ROM fetch subsystem

VERILATOR  ?= verilator
TOP        := tb_rom_subsys
FILELIST   := rom_subsys.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --Mdir $(BUILD_DIR)
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the log holds the pass line
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
